// ==== common/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 64;

    // major opcodes of the supported RV64I subset.
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one instruction word seen through each format.
    typedef union packed {
        r_type_t     r;
        i_type_t     i;
        u_type_t     u;
        logic [31:0] raw;
    } instr_u;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt,
        alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and, alu_addw, alu_subw,
        alu_sllw, alu_srlw, alu_sraw, alu_pass
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_rf = 2'd0,
        fwd_ex = 2'd1,
        fwd_wb = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        alu_op_t         op;
        logic [4:0]      rd;
        logic            we;
        logic            illegal;
        logic [xlen-1:0] pc;
    } de_ex_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [4:0]      rd;
        logic            we;
        logic            illegal;
        logic [xlen-1:0] pc;
    } ex_wb_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [4:0]      rd;
        logic            we;
        logic            illegal;
        logic [xlen-1:0] pc;
    } result_t;

endpackage

`default_nettype wire

// ==== decode/imm_gen.sv ====
`default_nettype none

module imm_gen import rv_isa_pkg::*; (
    input  instr_u          instr,
    output logic [xlen-1:0] imm
);

    logic is_shift;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;

    assign is_shift = (instr.i.funct3 == f3_sll) || (instr.i.funct3 == f3_sr);

    assign imm_i = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_u = {{(xlen-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};

    always_comb begin
        unique case (instr.i.opcode)
            opc_op_imm: begin
                // bit 30 selects arithmetic shift and is not part of the amount.
                if (is_shift) begin
                    imm = {{(xlen-6){1'b0}}, instr.i.imm[5:0]};
                end else begin
                    imm = imm_i;
                end
            end
            opc_op_imm_32: begin
                if (is_shift) begin
                    imm = {{(xlen-5){1'b0}}, instr.i.imm[4:0]};
                end else begin
                    imm = imm_i;
                end
            end
            opc_lui, opc_auipc: begin
                imm = imm_u;
            end
            default: begin
                imm = imm_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`default_nettype none

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    input  fetch_pkt_t      in_pkt,
    input  logic            ex_load,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  fwd_sel_t        fwd1,
    input  fwd_sel_t        fwd2,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] wb_result,
    output logic [4:0]      raddr1,
    output logic [4:0]      raddr2,
    output logic            rs1_used,
    output logic            rs2_used,
    output de_ex_t          de_ex
);

    instr_u instr;
    logic alt;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    alu_op_t op;
    logic we;
    logic illegal;
    logic r_type;

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_t sel,
                                               input logic [xlen-1:0] rf_val);
        logic [xlen-1:0] val;
        unique case (sel)
            fwd_ex:  val = ex_result;
            fwd_wb:  val = wb_result;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign instr.raw = in_pkt.instr;
    assign alt = instr.r.funct7[5];
    assign raddr1 = instr.r.rs1;
    assign raddr2 = instr.r.rs2;

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    always_comb begin
        op = alu_add;
        we = 1'b1;
        illegal = 1'b0;
        rs1_used = 1'b1;
        rs2_used = 1'b0;
        r_type = 1'b0;
        unique case (instr.r.opcode)
            opc_op, opc_op_imm: begin
                r_type = (instr.r.opcode == opc_op);
                rs2_used = r_type;
                unique case (instr.r.funct3)
                    f3_add:  op = (alt && r_type) ? alu_sub : alu_add;
                    f3_sll:  op = alu_sll;
                    f3_slt:  op = alu_slt;
                    f3_sltu: op = alu_sltu;
                    f3_xor:  op = alu_xor;
                    f3_sr:   op = alt ? alu_sra : alu_srl;
                    f3_or:   op = alu_or;
                    default: op = alu_and;
                endcase
            end
            opc_op_32, opc_op_imm_32: begin
                r_type = (instr.r.opcode == opc_op_32);
                rs2_used = r_type;
                unique case (instr.r.funct3)
                    f3_add:  op = (alt && r_type) ? alu_subw : alu_addw;
                    f3_sll:  op = alu_sllw;
                    f3_sr:   op = alt ? alu_sraw : alu_srlw;
                    default: illegal = 1'b1;
                endcase
            end
            opc_lui: begin
                op = alu_pass;
                rs1_used = 1'b0;
            end
            opc_auipc: begin
                rs1_used = 1'b0;
            end
            default: begin
                illegal = 1'b1;
                rs1_used = 1'b0;
            end
        endcase
        if (illegal) begin
            we = 1'b0;
        end
    end

    assign src1 = fwd_mux(fwd1, rdata1);
    assign src2 = fwd_mux(fwd2, rdata2);

    always_comb begin
        if (instr.r.opcode == opc_lui) begin
            op1 = '0;
        end else if (instr.r.opcode == opc_auipc) begin
            op1 = in_pkt.pc;
        end else begin
            op1 = src1;
        end
    end

    assign op2 = r_type ? src2 : imm;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            de_ex.we <= 1'b0;
            de_ex.illegal <= 1'b0;
        end else if (ex_load) begin
            de_ex.we <= we;
            de_ex.illegal <= illegal;
        end
    end

    always_ff @(posedge CLK) begin
        if (ex_load) begin
            de_ex.op1 <= op1;
            de_ex.op2 <= op2;
            de_ex.op <= op;
            de_ex.rd <= instr.r.rd;
            de_ex.pc <= in_pkt.pc;
        end
    end

    // an unsupported word never reaches execute with a register write.
    illegal_no_write_a: assert property (@(posedge CLK) disable iff (RESET)
        ex_load && illegal |=> de_ex.illegal && !de_ex.we);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

module reg_file import rv_isa_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

    x0_zero_a: assert property (@(posedge CLK) disable iff (RESET)
        regs[0] == '0);

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`default_nettype none

module exec_unit import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic            CLK,
    input  logic            RESET,
    input  de_ex_t          de_ex,
    input  logic            ex_load,
    input  logic            wb_load,
    output logic [4:0]      ex_rd,
    output logic            ex_we,
    output logic [xlen-1:0] ex_result,
    output logic [4:0]      wb_rd,
    output logic            wb_we,
    output logic [xlen-1:0] wb_result,
    output result_t         out_res
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] alu_res;
    ex_wb_t wb_q;

    function automatic logic [xlen-1:0] sext_w(input logic [31:0] w);
        return {{(xlen-32){w[31]}}, w};
    endfunction

    assign a = de_ex.op1;
    assign b = de_ex.op2;

    always_comb begin
        unique case (de_ex.op)
            alu_add:  alu_res = a + b;
            alu_sub:  alu_res = a - b;
            alu_sll:  alu_res = a << b[5:0];
            alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_res = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  alu_res = a ^ b;
            alu_srl:  alu_res = a >> b[5:0];
            alu_sra:  alu_res = $signed(a) >>> b[5:0];
            alu_or:   alu_res = a | b;
            alu_and:  alu_res = a & b;
            // word forms work on the low half and sign-extend bit 31.
            alu_addw: alu_res = sext_w(a[31:0] + b[31:0]);
            alu_subw: alu_res = sext_w(a[31:0] - b[31:0]);
            alu_sllw: alu_res = sext_w(a[31:0] << b[4:0]);
            alu_srlw: alu_res = sext_w(a[31:0] >> b[4:0]);
            alu_sraw: alu_res = sext_w($signed(a[31:0]) >>> b[4:0]);
            default:  alu_res = b;
        endcase
    end

    assign ex_rd = de_ex.rd;
    assign ex_we = de_ex.we;
    assign ex_result = alu_res;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wb_q.we <= 1'b0;
            wb_q.illegal <= 1'b0;
        end else if (wb_load) begin
            wb_q.we <= de_ex.we;
            wb_q.illegal <= de_ex.illegal;
        end
    end

    always_ff @(posedge CLK) begin
        if (wb_load) begin
            wb_q.result <= alu_res;
            wb_q.rd <= de_ex.rd;
            wb_q.pc <= de_ex.pc;
        end
    end

    assign wb_rd = wb_q.rd;
    assign wb_we = wb_q.we;
    assign wb_result = wb_q.result;
    assign out_res = result_t'(wb_q);

    // operands held in decode stay put until the next execute load.
    ex_hold_a: assert property (@(posedge CLK) disable iff (RESET)
        !ex_load |=> $stable(de_ex));

endmodule

`default_nettype wire

// ==== rtl/pipe_ctrl.sv ====
`default_nettype none

module pipe_ctrl import pipe_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       in_valid,
    input  logic       out_ready,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic       rs1_used,
    input  logic       rs2_used,
    input  logic [4:0] ex_rd,
    input  logic       ex_we,
    input  logic [4:0] wb_rd,
    input  logic       wb_we,
    output logic       in_ready,
    output logic       ex_load,
    output logic       wb_load,
    output logic       out_valid,
    output fwd_sel_t   fwd1,
    output fwd_sel_t   fwd2
);

    logic ex_valid;
    logic wb_valid;
    logic ex_adv;
    logic wb_adv;

    // the newer result in execute wins over writeback.
    function automatic fwd_sel_t pick(input logic [4:0] rs, input logic used);
        fwd_sel_t sel;
        sel = fwd_rf;
        if (used && rs != 5'd0) begin
            if (ex_valid && ex_we && ex_rd == rs) begin
                sel = fwd_ex;
            end else if (wb_valid && wb_we && wb_rd == rs) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    assign wb_adv = !wb_valid || out_ready;
    assign ex_adv = !ex_valid || wb_adv;

    assign in_ready = ex_adv;
    assign ex_load = in_valid && ex_adv;
    assign wb_load = ex_valid && wb_adv;
    assign out_valid = wb_valid;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (ex_adv) begin
                ex_valid <= in_valid;
            end
            if (wb_adv) begin
                wb_valid <= ex_valid;
            end
        end
    end

    always_comb begin
        fwd1 = pick(rs1, rs1_used);
        fwd2 = pick(rs2, rs2_used);
    end

    out_hold_a: assert property (@(posedge CLK) disable iff (RESET)
        out_valid && !out_ready |=> out_valid);

    full_freeze_a: assert property (@(posedge CLK) disable iff (RESET)
        out_valid && !out_ready && ex_valid |-> !in_ready ##1 ex_valid);

endmodule

`default_nettype wire

// ==== rtl/int_pipe.sv ====
`default_nettype none

module int_pipe import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       in_valid,
    output logic       in_ready,
    input  fetch_pkt_t in_pkt,
    output logic       out_valid,
    input  logic       out_ready,
    output result_t    out_res
);

    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic rs1_used;
    logic rs2_used;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    fwd_sel_t fwd1;
    fwd_sel_t fwd2;
    logic ex_load;
    logic wb_load;
    de_ex_t de_ex;
    logic [4:0] ex_rd;
    logic ex_we;
    logic [xlen-1:0] ex_result;
    logic [4:0] wb_rd;
    logic wb_we;
    logic [xlen-1:0] wb_result;

    pipe_ctrl u_pipe_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .rs1       (raddr1),
        .rs2       (raddr2),
        .rs1_used  (rs1_used),
        .rs2_used  (rs2_used),
        .ex_rd     (ex_rd),
        .ex_we     (ex_we),
        .wb_rd     (wb_rd),
        .wb_we     (wb_we),
        .in_ready  (in_ready),
        .ex_load   (ex_load),
        .wb_load   (wb_load),
        .out_valid (out_valid),
        .fwd1      (fwd1),
        .fwd2      (fwd2)
    );

    decode_stage u_decode (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_pkt    (in_pkt),
        .ex_load   (ex_load),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .fwd1      (fwd1),
        .fwd2      (fwd2),
        .ex_result (ex_result),
        .wb_result (wb_result),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .rs1_used  (rs1_used),
        .rs2_used  (rs2_used),
        .de_ex     (de_ex)
    );

    // the writeback entry commits on its output transfer.
    reg_file u_reg_file (
        .CLK    (CLK),
        .RESET  (RESET),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (wb_we && out_valid && out_ready),
        .waddr  (wb_rd),
        .wdata  (wb_result),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exec_unit u_exec (
        .CLK       (CLK),
        .RESET     (RESET),
        .de_ex     (de_ex),
        .ex_load   (ex_load),
        .wb_load   (wb_load),
        .ex_rd     (ex_rd),
        .ex_we     (ex_we),
        .ex_result (ex_result),
        .wb_rd     (wb_rd),
        .wb_we     (wb_we),
        .wb_result (wb_result),
        .out_res   (out_res)
    );

endmodule

`default_nettype wire

// ==== dv/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

`default_nettype none

// architectural register state as the model sees it.
logic [63:0] model_regs [32];

function automatic logic [63:0] word_ext(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                     input logic [63:0] a, input logic [63:0] b,
                                     input logic is_reg);
    logic [63:0] res;
    case (f3)
        3'd0: res = (is_reg && alt) ? a - b : a + b;
        3'd1: res = a << b[5:0];
        3'd2: res = {63'b0, $signed(a) < $signed(b)};
        3'd3: res = {63'b0, a < b};
        3'd4: res = a ^ b;
        3'd5: begin
            if (alt) begin
                res = $signed(a) >>> b[5:0];
            end else begin
                res = a >> b[5:0];
            end
        end
        3'd6: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
                                     input logic [63:0] a, input logic [63:0] b,
                                     input logic is_reg, output logic ill);
    logic [31:0] w;
    ill = 1'b0;
    case (f3)
        3'd0: w = (is_reg && alt) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1: w = a[31:0] << b[4:0];
        3'd5: begin
            if (alt) begin
                w = $signed(a[31:0]) >>> b[4:0];
            end else begin
                w = a[31:0] >> b[4:0];
            end
        end
        default: begin
            w = '0;
            ill = 1'b1;
        end
    endcase
    return word_ext(w);
endfunction

// result of one instruction against the current model state.
function automatic logic [63:0] model_result(input logic [31:0] ins, input logic [63:0] pc,
                                             output logic ill);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] immi;
    logic [63:0] immu;
    logic [63:0] res;
    a = model_regs[ins[19:15]];
    b = model_regs[ins[24:20]];
    immi = {{52{ins[31]}}, ins[31:20]};
    immu = {{32{ins[31]}}, ins[31:12], 12'b0};
    ill = 1'b0;
    res = '0;
    case (ins[6:0])
        rv_isa_pkg::opc_op:        res = alu64(ins[14:12], ins[30], a, b, 1'b1);
        rv_isa_pkg::opc_op_imm:    res = alu64(ins[14:12], ins[30], a, immi, 1'b0);
        rv_isa_pkg::opc_op_32:     res = alu32(ins[14:12], ins[30], a, b, 1'b1, ill);
        rv_isa_pkg::opc_op_imm_32: res = alu32(ins[14:12], ins[30], a, immi, 1'b0, ill);
        rv_isa_pkg::opc_lui:       res = immu;
        rv_isa_pkg::opc_auipc:     res = pc + immu;
        default:                   ill = 1'b1;
    endcase
    return res;
endfunction

`default_nettype wire

`endif

// ==== dv/int_pipe_tb.sv ====
`default_nettype none

module int_pipe_tb import rv_isa_pkg::*, pipe_pkg::*;;

    localparam int n_rand = 200;
    localparam int n_word = 200;
    localparam int n_dep = 150;
    localparam int n_stall = 200;
    localparam int n_ill = 100;
    localparam int cycle_limit = (1 + n_rand + n_word + n_dep + n_stall + n_ill) * 12 + 200;

    logic CLK;
    logic RESET;
    logic in_valid;
    logic in_ready;
    fetch_pkt_t in_pkt;
    logic out_valid;
    logic out_ready;
    result_t out_res;

    logic [31:0] lfsr = 32'h7bfc;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int ready_level = 8;
    int gap_level = 0;
    logic lat_check = 1'b0;
    logic [63:0] pc = 64'h8000_0000;
    result_t exp_q [$];
    int acc_q [$];
    logic held_valid = 1'b0;
    result_t held_res;

    `include "rv_model.svh"

    int_pipe dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    // mostly x1..x4 so that dependences show up often.
    function automatic logic [4:0] pick_reg();
        if (rnd(2) != 0) begin
            return 5'(rnd(2) + 1);
        end
        return 5'(rnd(5));
    endfunction

    function automatic logic [31:0] reg_reg_instr(input logic [6:0] opc);
        logic [2:0] f3;
        logic [1:0] sel;
        logic alt;
        f3 = 3'(rnd(3));
        if (opc == opc_op_32) begin
            sel = 2'(rnd(2));
            f3 = (sel == 0) ? 3'd0 : (sel == 1) ? 3'd1 : 3'd5;
        end
        alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rnd(1)) : 1'b0;
        return {1'b0, alt, 5'b0, pick_reg(), pick_reg(), f3, pick_reg(), opc};
    endfunction

    function automatic logic [31:0] reg_imm_instr(input logic [6:0] opc);
        logic [2:0] f3;
        logic [1:0] sel;
        logic [11:0] imm;
        f3 = 3'(rnd(3));
        if (opc == opc_op_imm_32) begin
            sel = 2'(rnd(2));
            f3 = (sel == 0) ? 3'd0 : (sel == 1) ? 3'd1 : 3'd5;
        end
        imm = 12'(rnd(12));
        if (f3 == 3'd1) begin
            imm[11:6] = 6'b0;
        end else if (f3 == 3'd5) begin
            imm[11:6] = {1'b0, imm[10], 4'b0};
        end
        if (opc == opc_op_imm_32 && f3 != 3'd0) begin
            imm[5] = 1'b0;
        end
        return {imm, pick_reg(), f3, pick_reg(), opc};
    endfunction

    function automatic logic [31:0] upper_imm_instr(input logic [6:0] opc);
        return {20'(rnd(20)), pick_reg(), opc};
    endfunction

    function automatic logic [31:0] illegal_instr();
        logic [6:0] opc;
        opc = {5'(rnd(5)), 2'b11};
        if (opc == opc_op || opc == opc_op_imm || opc == opc_op_32 ||
            opc == opc_op_imm_32 || opc == opc_lui || opc == opc_auipc) begin
            opc = 7'b1110011;
        end
        return {25'(rnd(25)), opc};
    endfunction

    function automatic logic [31:0] random_instr();
        case (rnd(3))
            0: return reg_reg_instr(opc_op);
            1: return reg_imm_instr(opc_op_imm);
            2: return reg_reg_instr(opc_op_32);
            3: return reg_imm_instr(opc_op_imm_32);
            4: return upper_imm_instr(opc_lui);
            5: return upper_imm_instr(opc_auipc);
            6: return illegal_instr();
            default: return reg_imm_instr(opc_op_imm);
        endcase
    endfunction

    task automatic step_cycle();
        @(posedge CLK);
        #2;
        out_ready = (rnd(3) < ready_level);
    endtask

    task automatic send_instr(input logic [31:0] ins);
        logic accepted;
        while (rnd(3) < gap_level) begin
            step_cycle();
        end
        in_valid = 1'b1;
        in_pkt = '{pc: pc, instr: ins};
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge CLK);
            accepted = in_ready;
            step_cycle();
        end
        in_valid = 1'b0;
        pc = pc + 64'd4;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        step_cycle();
    endtask

    task automatic compare_field(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    always @(negedge CLK) begin
        result_t exp;
        logic ill;
        int acc;
        if (!RESET) begin
            if (held_valid) begin
                checks++;
                assert (out_valid && out_res === held_res) else begin
                    errors++;
                    $display("a held result changed or vanished at time %0t", $time);
                end
            end
            held_valid = out_valid && !out_ready;
            held_res = out_res;
            if (out_valid && out_ready) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("a result came out with no instruction pending at %0t", $time);
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    if (!exp.illegal) begin
                        compare_field(out_res.result, exp.result, "result");
                    end
                    compare_field(64'(out_res.rd), 64'(exp.rd), "rd");
                    compare_field(64'(out_res.we), 64'(exp.we), "write enable");
                    compare_field(64'(out_res.illegal), 64'(exp.illegal), "illegal flag");
                    compare_field(out_res.pc, exp.pc, "pc");
                    if (lat_check) begin
                        compare_field(64'(cycles - acc), 64'd2, "latency");
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp.result = model_result(in_pkt.instr, in_pkt.pc, ill);
                exp.rd = in_pkt.instr[11:7];
                exp.we = !ill;
                exp.illegal = ill;
                exp.pc = in_pkt.pc;
                if (!ill && exp.rd != 5'd0) begin
                    model_regs[exp.rd] = exp.result;
                end
                exp_q.push_back(exp);
                acc_q.push_back(cycles);
            end
        end
    end

    initial begin
        int c0;
        int e0;
        logic [31:0] ins;
        logic [4:0] prev1;
        logic [4:0] prev2;
        RESET = 1'b1;
        in_valid = 1'b0;
        in_pkt = '0;
        out_ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge CLK);
        #2;
        RESET = 1'b0;
        out_ready = 1'b1;

        c0 = checks;
        e0 = errors;
        @(negedge CLK);
        checks++;
        assert (!out_valid && in_ready) else begin
            errors++;
            $display("after reset out_valid was high or in_ready was low");
        end
        step_cycle();
        lat_check = 1'b1;
        send_instr({12'd5, 5'd0, f3_add, 5'd1, opc_op_imm});
        drain();
        lat_check = 1'b0;
        report("reset and first result", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < n_rand; i++) begin
            send_instr(rnd(1) ? reg_reg_instr(opc_op) : reg_imm_instr(opc_op_imm));
        end
        drain();
        report("random op and op-imm", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < n_word; i++) begin
            case (rnd(2))
                0: ins = reg_reg_instr(opc_op_32);
                1: ins = reg_imm_instr(opc_op_imm_32);
                2: ins = upper_imm_instr(opc_lui);
                default: ins = upper_imm_instr(opc_auipc);
            endcase
            send_instr(ins);
        end
        drain();
        report("word forms, lui and auipc", c0, e0);

        c0 = checks;
        e0 = errors;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < n_dep; i++) begin
            ins = rnd(1) ? reg_reg_instr(opc_op) : reg_imm_instr(opc_op_imm);
            ins[19:15] = rnd(1) ? prev1 : prev2;
            ins[24:20] = rnd(1) ? prev2 : prev1;
            ins[11:7] = 5'(rnd(2) + 1);
            prev2 = prev1;
            prev1 = ins[11:7];
            send_instr(ins);
        end
        drain();
        report("back-to-back dependences", c0, e0);

        c0 = checks;
        e0 = errors;
        ready_level = 3;
        gap_level = 2;
        for (int i = 0; i < n_stall; i++) begin
            send_instr(random_instr());
        end
        ready_level = 8;
        drain();
        report("random stalls", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < n_ill; i++) begin
            case (rnd(2))
                0: ins = illegal_instr();
                1: ins = {12'(rnd(12)), pick_reg(), f3_add, 5'd0, opc_op_imm};
                2: ins = {7'b0, 5'd0, pick_reg(), f3_or, pick_reg(), opc_op};
                default: ins = {12'd0, 5'd0, f3_add, pick_reg(), opc_op_imm};
            endcase
            send_instr(ins);
        end
        drain();
        report("illegal opcodes and x0", c0, e0);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== int_pipe.f ====
common/rv_isa_pkg.sv
common/pipe_pkg.sv
decode/imm_gen.sv
decode/decode_stage.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/pipe_ctrl.sv
rtl/int_pipe.sv
+incdir+dv
dv/int_pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = int_pipe_tb
FILELIST  = int_pipe.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) dv/rv_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
